/* tiny_rv_pkg.sv */
// shared definitions for the tiny_rv core
// data and register widths, the reset fetch address, opcodes in use,
// alu operation codes and the instruction word with its format views
// rtl files pull these in with a wildcard import in the module header
`default_nettype none

package tiny_rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// rv32i major opcodes handled by the core
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} op_e;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_pass_b = 3'd5  // lui
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered, bit 0 is implied zero
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;  // upper 20 bits
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, decoded per opcode
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_u;

endpackage

`default_nettype wire

/* mem_bus_if.sv */
// one requester's memory channel
// req and ack are single-cycle strobes, only one request open at a time
// addr, we and wdata are valid in the req cycle, rdata in the ack cycle
`default_nettype none

interface mem_bus_if import tiny_rv_pkg::*; ();

	logic            req;
	logic            we;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] wdata;
	logic            ack;
	logic [xlen-1:0] rdata;

	modport requester (
		output req, we, addr, wdata,
		input  ack, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output ack, rdata
	);

endinterface

`default_nettype wire

/* fetch_unit.sv */
// instruction fetch for tiny_rv
// holds one fetched word for the execute stage and its address in pc,
// fetches the next word only after the held one is taken,
// and restarts from target on redirect
// a redirect only comes with a take, so no fetch is in flight at that time
`default_nettype none

module fetch_unit import tiny_rv_pkg::*; (
	input  logic            sys_clk,
	input  logic            rst,
	mem_bus_if.requester    ibus,
	output instr_u          instr,
	output logic            instr_valid,
	input  logic            take,
	input  logic            redirect,
	input  logic [xlen-1:0] target,
	output logic [xlen-1:0] pc
);

	logic [xlen-1:0] fetch_addr;  // address of next or in-flight fetch
	logic            busy;        // fetch outstanding
	logic            load_word;

	assign ibus.req   = !busy && !instr_valid;
	assign ibus.we    = 1'b0;
	assign ibus.addr  = fetch_addr;
	assign ibus.wdata = '0;

	assign load_word = busy && ibus.ack;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			fetch_addr  <= reset_pc;
			busy        <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			if (ibus.req)
				busy <= 1'b1;
			if (take)
				instr_valid <= 1'b0;
			if (load_word) begin
				busy        <= 1'b0;
				instr_valid <= 1'b1;
				fetch_addr  <= fetch_addr + 32'd4;
			end
			if (redirect) begin
				instr_valid <= 1'b0;
				fetch_addr  <= target;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load_word) begin
			instr <= ibus.rdata;
			pc    <= fetch_addr;
		end
	end

	// the arbiter only acks an open fetch
	a_ack_open: assert property (@(posedge sys_clk) disable iff (rst)
		ibus.ack |-> busy);

endmodule

`default_nettype wire

/* reg_file.sv */
// 32 x 32 register file
// synchronous write, combinational reads, x0 is never written
`default_nettype none

module reg_file import tiny_rv_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  rst,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [xlen-1:0]       wr_data,
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0]       rs1_data,
	output logic [xlen-1:0]       rs2_data
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			for (int i = 0; i < 2**reg_addr_w; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;  // x0 stays zero from reset
		end
	end

	// read during the execute cycle, write lands at its end
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* alu.sv */
// combinational alu for tiny_rv
// add, sub, and, or, xor and pass of operand b,
// plus an equality flag used for beq and bne
`default_nettype none

module alu import tiny_rv_pkg::*; (
	input  alu_op_e         op,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	output logic [xlen-1:0] result,
	output logic            equal
);

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_pass_b: result = b;
			default:    result = a + b;
		endcase
	end

	// compare is independent of op
	assign equal = (a == b);

endmodule

`default_nettype wire

/* exec_stage.sv */
// decode and execute stage for tiny_rv
// takes the held instruction when no data access is open, reads and writes
// the register file in the same cycle, posts loads and stores on dbus and
// writes load data back in the ack cycle, resolves branches and jal
`default_nettype none

module exec_stage import tiny_rv_pkg::*; (
	input  logic            sys_clk,
	input  logic            rst,
	input  instr_u          instr,
	input  logic            instr_valid,
	input  logic [xlen-1:0] pc,
	output logic            take,
	output logic            redirect,
	output logic [xlen-1:0] target,
	mem_bus_if.requester    dbus
);

	op_e                   opcode;
	alu_op_e               alu_op;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm_b;
	logic [xlen-1:0]       imm_u;
	logic [xlen-1:0]       imm_j;
	logic [xlen-1:0]       imm;
	logic [xlen-1:0]       alu_b;
	logic [xlen-1:0]       alu_result;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic [xlen-1:0]       wb_data;
	logic [reg_addr_w-1:0] wr_addr;
	logic [reg_addr_w-1:0] ld_rd;    // load destination
	logic                  alu_equal;
	logic                  use_imm;
	logic                  writes_rd;
	logic                  is_mem;
	logic                  br_taken;
	logic                  reg_we;
	logic                  mem_busy;  // data access open
	logic                  ld_pend;

	assign opcode = op_e'(instr.r_fmt.opcode);

	assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
	assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
	assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
		instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
	assign imm_u = {instr.u_fmt.imm, 12'h000};
	assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
		instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

	always_comb begin
		alu_op    = alu_add;
		imm       = imm_i;
		use_imm   = 1'b0;
		writes_rd = 1'b0;
		case (opcode)
			opc_op: begin
				writes_rd = 1'b1;
				case (instr.r_fmt.funct3)
					3'b000:  alu_op = instr.r_fmt.funct7[5] ? alu_sub : alu_add;
					3'b100:  alu_op = alu_xor;
					3'b110:  alu_op = alu_or;
					3'b111:  alu_op = alu_and;
					default: alu_op = alu_add;
				endcase
			end
			opc_op_imm: begin  // addi only
				use_imm   = 1'b1;
				writes_rd = 1'b1;
			end
			opc_lui: begin
				alu_op    = alu_pass_b;
				imm       = imm_u;
				use_imm   = 1'b1;
				writes_rd = 1'b1;
			end
			opc_load:  use_imm = 1'b1;
			opc_store: begin
				imm     = imm_s;
				use_imm = 1'b1;
			end
			opc_jal:   writes_rd = 1'b1;
			default: ;
		endcase
	end

	assign alu_b  = use_imm ? imm : rs2_data;
	assign is_mem = (opcode == opc_load) || (opcode == opc_store);

	// one instruction per cycle unless a load or store is still open
	assign take = instr_valid && !mem_busy;

	// beq is funct3 000, bne is 001
	assign br_taken = (opcode == opc_branch) &&
		(instr.b_fmt.funct3[0] ? !alu_equal : alu_equal);
	assign redirect = take && ((opcode == opc_jal) || br_taken);
	assign target   = pc + ((opcode == opc_jal) ? imm_j : imm_b);

	assign dbus.req   = take && is_mem;
	assign dbus.we    = (opcode == opc_store);
	assign dbus.addr  = alu_result;  // rs1 + imm
	assign dbus.wdata = rs2_data;

	// load data owns the write port in its ack cycle
	assign reg_we  = (take && writes_rd) || (dbus.ack && ld_pend);
	assign wr_addr = dbus.ack ? ld_rd : instr.r_fmt.rd;
	assign wb_data = dbus.ack ? dbus.rdata :
		((opcode == opc_jal) ? pc + 32'd4 : alu_result);

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			mem_busy <= 1'b0;
			ld_pend  <= 1'b0;
		end else if (dbus.req) begin
			mem_busy <= 1'b1;
			ld_pend  <= (opcode == opc_load);
		end else if (dbus.ack) begin
			mem_busy <= 1'b0;
			ld_pend  <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (dbus.req)
			ld_rd <= instr.r_fmt.rd;
	end

	reg_file reg_file (
		.sys_clk  (sys_clk),
		.rst      (rst),
		.we       (reg_we),
		.wr_addr  (wr_addr),
		.wr_data  (wb_data),
		.rs1_addr (instr.r_fmt.rs1),
		.rs2_addr (instr.r_fmt.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu alu (
		.op     (alu_op),
		.a      (rs1_data),
		.b      (alu_b),
		.result (alu_result),
		.equal  (alu_equal)
	);

	// a data ack only answers an access that is still open
	a_ack_in_access: assert property (@(posedge sys_clk) disable iff (rst)
		dbus.ack |-> mem_busy);

endmodule

`default_nettype wire

/* mem_arbiter.sv */
// shares the single external memory port between fetch and data channels
// a request is forwarded the cycle after it is posted when the port is free,
// otherwise it waits; data goes before fetch when both wait
// the ack is steered back to the owner of the open request in the same cycle
`default_nettype none

module mem_arbiter import tiny_rv_pkg::*; (
	input  logic            sys_clk,
	input  logic            rst,
	mem_bus_if.arbiter      ibus,
	mem_bus_if.arbiter      dbus,
	output logic            mem_req,
	output logic            mem_we,
	output logic [xlen-1:0] mem_addr,
	output logic [xlen-1:0] mem_wdata,
	input  logic            mem_ack,
	input  logic [xlen-1:0] mem_rdata
);

	logic            pend_i;
	logic            pend_d;
	logic            open;      // request sent, no ack yet
	logic            owner_d;   // open request belongs to dbus
	logic            i_wait;
	logic            d_wait;
	logic            grant;
	logic            i_we_q;
	logic            d_we_q;
	logic [xlen-1:0] i_addr_q;
	logic [xlen-1:0] d_addr_q;
	logic [xlen-1:0] i_wdata_q;
	logic [xlen-1:0] d_wdata_q;

	assign i_wait = pend_i || ibus.req;
	assign d_wait = pend_d || dbus.req;
	assign grant  = (!open || mem_ack) && (i_wait || d_wait);

	assign dbus.ack   = mem_ack && owner_d;
	assign ibus.ack   = mem_ack && !owner_d;
	assign dbus.rdata = mem_rdata;
	assign ibus.rdata = mem_rdata;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			mem_req <= 1'b0;
			open    <= 1'b0;
			owner_d <= 1'b0;
			pend_i  <= 1'b0;
			pend_d  <= 1'b0;
		end else begin
			mem_req <= grant;
			if (mem_ack)
				open <= 1'b0;
			if (ibus.req)
				pend_i <= 1'b1;
			if (dbus.req)
				pend_d <= 1'b1;
			if (grant) begin
				open    <= 1'b1;
				owner_d <= d_wait;
				if (d_wait)
					pend_d <= 1'b0;
				else
					pend_i <= 1'b0;
			end
		end
	end

	// request payload, taken live in the post cycle or from the latch
	always_ff @(posedge sys_clk) begin
		if (ibus.req) begin
			i_we_q    <= ibus.we;
			i_addr_q  <= ibus.addr;
			i_wdata_q <= ibus.wdata;
		end
		if (dbus.req) begin
			d_we_q    <= dbus.we;
			d_addr_q  <= dbus.addr;
			d_wdata_q <= dbus.wdata;
		end
		if (grant && d_wait) begin
			mem_we    <= dbus.req ? dbus.we : d_we_q;
			mem_addr  <= dbus.req ? dbus.addr : d_addr_q;
			mem_wdata <= dbus.req ? dbus.wdata : d_wdata_q;
		end else if (grant) begin
			mem_we    <= ibus.req ? ibus.we : i_we_q;
			mem_addr  <= ibus.req ? ibus.addr : i_addr_q;
			mem_wdata <= ibus.req ? ibus.wdata : i_wdata_q;
		end
	end

	// memory answers only the one open request, never in its request cycle
	a_one_open: assert property (@(posedge sys_clk) disable iff (rst)
		mem_ack |-> open && !mem_req);

endmodule

`default_nettype wire

/* cpu_top.sv */
// tiny_rv cpu top level
// two-stage rv32i subset core: fetch feeds one held word to the execute stage,
// both share a single external memory port through the arbiter
// mem_req is a one-cycle strobe, mem_ack answers it one or more cycles later
`default_nettype none

module cpu_top import tiny_rv_pkg::*; (
	input  logic            sys_clk,
	input  logic            rst,
	output logic            mem_req,
	output logic            mem_we,
	output logic [xlen-1:0] mem_addr,
	output logic [xlen-1:0] mem_wdata,
	input  logic            mem_ack,
	input  logic [xlen-1:0] mem_rdata
);

	instr_u          instr;
	logic            instr_valid;
	logic            take;
	logic            redirect;
	logic [xlen-1:0] target;
	logic [xlen-1:0] pc;

	mem_bus_if ibus ();  // fetch channel
	mem_bus_if dbus ();  // load/store channel

	fetch_unit fetch_unit (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.ibus        (ibus.requester),
		.instr       (instr),
		.instr_valid (instr_valid),
		.take        (take),
		.redirect    (redirect),
		.target      (target),
		.pc          (pc)
	);

	exec_stage exec_stage (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.pc          (pc),
		.take        (take),
		.redirect    (redirect),
		.target      (target),
		.dbus        (dbus.requester)
	);

	mem_arbiter mem_arbiter (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.ibus      (ibus.arbiter),
		.dbus      (dbus.arbiter),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

/* tb_cpu_top.sv */
// testbench for the tiny_rv cpu top level
// a 256-word memory model with random ack latency serves the memory port,
// each test loads a small program, resets the core and runs it until the
// program stores to the done word at 0x3fc, then checks memory contents
`default_nettype none

module tb_cpu_top import tiny_rv_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_tests = 5;
	localparam logic [xlen-1:0] done_addr = 32'h0000_03fc;

	logic            sys_clk = 1'b0;
	logic            rst = 1'b1;
	logic            mem_req;
	logic            mem_we;
	logic [xlen-1:0] mem_addr;
	logic [xlen-1:0] mem_wdata;
	logic            mem_ack = 1'b0;
	logic [xlen-1:0] mem_rdata = '0;

	logic [31:0] mem [256];
	logic        write_ok [256];  // words a program may store to
	logic [31:0] prog [$];
	logic [31:0] ok_addrs [$];
	logic [31:0] ls_saved [6];
	logic [11:0] ls_vals [3];
	logic [15:0] lfsr = 16'd29755;
	logic        pend = 1'b0;
	logic [7:0]  pend_idx;
	int          wait_cnt;
	logic        done = 1'b0;
	logic        seen_req = 1'b0;
	logic [31:0] first_addr;
	logic        first_we;
	int          req_count;
	int          ack_count;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	always #20 sys_clk = ~sys_clk;

	cpu_top dut (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	// galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic step_lfsr();
		logic b;
		b = lfsr[0];
		lfsr = (lfsr >> 1) ^ (b ? 16'hb400 : 16'h0000);
		return b;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], step_lfsr()};
		return v;
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] fill_value(input logic [7:0] idx);
		return {16'hc0de, idx, ~idx};
	endfunction

	// rv32i encodings
	function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] add_imm(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] load_upper(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
		assert (addr[31:10] == '0 && addr[1:0] == 2'b00 && write_ok[addr[9:2]]) else begin
			$display("%0t: store to unexpected address %h", $time, addr);
			errors++;
		end
		mem[addr[9:2]] = data;
		if (addr == done_addr)
			done = 1'b1;
	endtask

	// memory model with one open request and an ack 1 to 4 cycles after mem_req
	always @(posedge sys_clk) begin
		if (rst) begin
			mem_ack   <= 1'b0;
			pend      = 1'b0;
			done      = 1'b0;
			seen_req  = 1'b0;
			req_count = 0;
			ack_count = 0;
		end else begin
			mem_ack <= 1'b0;
			if (mem_req) begin
				assert (!pend) else begin
					$display("%0t: memory request sent while the previous one is open", $time);
					errors++;
				end
				if (!seen_req) begin
					first_addr = mem_addr;
					first_we   = mem_we;
					seen_req   = 1'b1;
				end
				req_count++;
				pend     = 1'b1;
				pend_idx = mem_addr[9:2];
				wait_cnt = int'(random_bits(2));  // extra cycles beyond one
				if (mem_we)
					write_word(mem_addr, mem_wdata);
			end
			if (pend) begin
				if (wait_cnt == 0) begin
					mem_ack   <= 1'b1;
					mem_rdata <= mem[pend_idx];
					pend = 1'b0;
					ack_count++;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	task automatic check_word(input logic [31:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] got;
		got = mem[addr[9:2]];
		assert (got === exp) else begin
			$display("FAILED at %0t ns: mem[%h] (%s) got %h, expected %h",
				$time, addr, what, got, exp);
			errors++;
		end
	endtask

	// reset with the program loaded and run until the done store
	task automatic run_program();
		@(posedge sys_clk);
		rst <= 1'b1;
		@(posedge sys_clk);
		foreach (mem[i]) begin
			mem[i]      = fill_value(8'(i));
			write_ok[i] = 1'b0;
		end
		foreach (prog[i])
			mem[i] = prog[i];
		foreach (ok_addrs[i])
			write_ok[ok_addrs[i][9:2]] = 1'b1;
		repeat (7) begin
			@(negedge sys_clk);
			assert (mem_req === 1'b0) else begin
				$display("FAILED at %0t ns: mem_req got %b in reset, expected 0", $time, mem_req);
				errors++;
			end
			@(posedge sys_clk);
		end
		rst <= 1'b0;
		while (!done)
			@(negedge sys_clk);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic reset_and_first_fetch();
		int err0;
		err0 = errors;
		prog = {};
		prog.push_back(store_word(5'd0, 5'd0, 12'h3fc));
		prog.push_back(jump_link(5'd0, 21'd0));
		ok_addrs = {done_addr};
		run_program();
		assert (first_addr === reset_pc && first_we === 1'b0) else begin
			$display("FAILED at %0t ns: first mem_addr got %h (we %b), expected %h read",
				$time, first_addr, first_we, reset_pc);
			errors++;
		end
		finish_test("reset and first fetch", err0);
	endtask

	task automatic alu_and_immediates();
		int          err0;
		logic [11:0] ia;
		logic [11:0] ib;
		logic [19:0] up;
		logic [31:0] ea;
		logic [31:0] eb;
		logic [31:0] eu;
		logic [31:0] exp [11];
		err0 = errors;
		ia = 12'(random_bits(12));
		ib = 12'(random_bits(12));
		up = 20'(random_bits(20));
		ea = sext12(ia);
		eb = sext12(ib);
		eu = {up, 12'h000};
		prog = {};
		ok_addrs = {done_addr};
		prog.push_back(add_imm(5'd1, 5'd0, ia));
		prog.push_back(add_imm(5'd2, 5'd0, ib));
		prog.push_back(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));  // add
		prog.push_back(reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));  // sub
		prog.push_back(reg_op(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
		prog.push_back(reg_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
		prog.push_back(reg_op(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
		prog.push_back(load_upper(5'd8, up));
		prog.push_back(add_imm(5'd9, 5'd8, ia));
		prog.push_back(add_imm(5'd0, 5'd1, 12'h05b));  // x0 must ignore this
		prog.push_back(reg_op(7'h00, 3'b000, 5'd10, 5'd0, 5'd1));
		for (int r = 1; r <= 10; r++) begin
			prog.push_back(store_word(5'(r), 5'd0, 12'(32'h200 + 4 * (r - 1))));
			ok_addrs.push_back(32'h200 + 4 * (r - 1));
		end
		prog.push_back(store_word(5'd0, 5'd0, 12'h228));
		ok_addrs.push_back(32'h228);
		prog.push_back(store_word(5'd0, 5'd0, 12'h3fc));
		prog.push_back(jump_link(5'd0, 21'd0));
		exp = '{ea, eb, ea + eb, ea - eb, ea & eb, ea | eb, ea ^ eb, eu, eu + ea, ea, 32'd0};
		run_program();
		for (int k = 0; k < 11; k++)
			check_word(32'h200 + 4 * k, exp[k], "alu result");
		finish_test("alu and immediates", err0);
	endtask

	task automatic build_load_store();
		prog = {};
		ok_addrs = {done_addr};
		for (int k = 0; k < 3; k++) begin
			prog.push_back(add_imm(5'(k + 1), 5'd0, ls_vals[k]));
			prog.push_back(store_word(5'(k + 1), 5'd0, 12'(32'h100 + 4 * k)));
		end
		prog.push_back(add_imm(5'd4, 5'd0, 12'h100));  // base pointer
		prog.push_back(load_word(5'd5, 5'd4, 12'h000));
		prog.push_back(load_word(5'd6, 5'd4, 12'h004));
		prog.push_back(load_word(5'd7, 5'd4, 12'h008));
		prog.push_back(reg_op(7'h00, 3'b000, 5'd8, 5'd5, 5'd6));
		prog.push_back(reg_op(7'h00, 3'b000, 5'd8, 5'd8, 5'd7));
		prog.push_back(store_word(5'd8, 5'd4, 12'h00c));
		prog.push_back(load_word(5'd9, 5'd0, 12'h10c));
		prog.push_back(store_word(5'd9, 5'd4, 12'h010));
		prog.push_back(load_word(5'd10, 5'd0, 12'h180));  // word never stored
		prog.push_back(store_word(5'd10, 5'd4, 12'h014));
		prog.push_back(store_word(5'd0, 5'd0, 12'h3fc));
		prog.push_back(jump_link(5'd0, 21'd0));
		for (int k = 0; k < 6; k++)
			ok_addrs.push_back(32'h100 + 4 * k);
	endtask

	task automatic check_load_store(input string what);
		logic [31:0] exp [6];
		for (int k = 0; k < 3; k++)
			exp[k] = sext12(ls_vals[k]);
		exp[3] = exp[0] + exp[1] + exp[2];
		exp[4] = exp[3];
		exp[5] = fill_value(8'h60);
		for (int k = 0; k < 6; k++)
			check_word(32'h100 + 4 * k, exp[k], what);
	endtask

	task automatic loads_and_stores();
		int err0;
		err0 = errors;
		for (int k = 0; k < 3; k++)
			ls_vals[k] = 12'(random_bits(12));
		build_load_store();
		run_program();
		check_load_store("load/store");
		for (int k = 0; k < 6; k++)
			ls_saved[k] = mem[8'h40 + k];
		finish_test("loads and stores", err0);
	endtask

	task automatic branches_and_jal();
		int err0;
		err0 = errors;
		prog = {};
		prog.push_back(add_imm(5'd1, 5'd0, 12'd7));                // 0x00
		prog.push_back(add_imm(5'd2, 5'd0, 12'd7));
		prog.push_back(add_imm(5'd3, 5'd0, 12'd9));
		prog.push_back(branch_op(3'b000, 5'd1, 5'd2, 13'd8));     // beq taken
		prog.push_back(store_word(5'd1, 5'd0, 12'h300));          // 0x10 skipped
		prog.push_back(add_imm(5'd10, 5'd0, 12'h011));
		prog.push_back(store_word(5'd10, 5'd0, 12'h200));
		prog.push_back(branch_op(3'b000, 5'd1, 5'd3, 13'd8));     // beq not taken
		prog.push_back(add_imm(5'd11, 5'd0, 12'h022));            // 0x20
		prog.push_back(store_word(5'd11, 5'd0, 12'h204));
		prog.push_back(branch_op(3'b001, 5'd1, 5'd3, 13'd8));     // bne taken
		prog.push_back(store_word(5'd1, 5'd0, 12'h304));          // skipped
		prog.push_back(add_imm(5'd12, 5'd0, 12'h033));            // 0x30
		prog.push_back(store_word(5'd12, 5'd0, 12'h208));
		prog.push_back(branch_op(3'b001, 5'd1, 5'd2, 13'd8));     // bne not taken
		prog.push_back(add_imm(5'd13, 5'd0, 12'h044));
		prog.push_back(store_word(5'd13, 5'd0, 12'h20c));         // 0x40
		prog.push_back(jump_link(5'd5, 21'd12));                  // 0x44 jumps to 0x50
		prog.push_back(store_word(5'd1, 5'd0, 12'h308));          // skipped
		prog.push_back(store_word(5'd1, 5'd0, 12'h30c));          // skipped
		prog.push_back(store_word(5'd5, 5'd0, 12'h210));          // 0x50 link
		prog.push_back(store_word(5'd0, 5'd0, 12'h3fc));
		prog.push_back(jump_link(5'd0, 21'd0));
		ok_addrs = {done_addr, 32'h200, 32'h204, 32'h208, 32'h20c, 32'h210};
		run_program();
		check_word(32'h200, 32'h11, "beq taken marker");
		check_word(32'h204, 32'h22, "beq not taken marker");
		check_word(32'h208, 32'h33, "bne taken marker");
		check_word(32'h20c, 32'h44, "bne not taken marker");
		check_word(32'h210, 32'h48, "jal link");
		for (int k = 0; k < 4; k++)
			check_word(32'h300 + 4 * k, fill_value(8'(8'hc0 + k)), "wrong path word");
		finish_test("branches and jal", err0);
	endtask

	task automatic arbitration_under_latency();
		int err0;
		err0 = errors;
		build_load_store();
		run_program();
		check_load_store("load/store rerun");
		for (int k = 0; k < 6; k++)
			check_word(32'h100 + 4 * k, ls_saved[k], "same as first run");
		assert (req_count > 0 && (req_count == ack_count || req_count == ack_count + 1))
		else begin
			$display("%0t: %0d memory requests but %0d acks", $time, req_count, ack_count);
			errors++;
		end
		finish_test("arbitration under latency", err0);
	endtask

	initial begin
		reset_and_first_fetch();
		alu_and_immediates();
		loads_and_stores();
		branches_and_jal();
		arbitration_under_latency();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// stop a hung run
	initial begin
		repeat (num_tests * 2000) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, a test did not finish", num_tests * 2000);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tiny_rv.f */
tiny_rv_pkg.sv
mem_bus_if.sv
fetch_unit.sv
reg_file.sv
alu.sv
exec_stage.sv
mem_arbiter.sv
cpu_top.sv
tb_cpu_top.sv

/* Makefile */
# Verilator build and run for the tiny_rv core and its testbench
# make        build and run, pass or fail taken from the log
# make lint   lint all sources
# make clean  remove build output and log

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= tiny_rv.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
